// ==== hw/epu_config.svh ====
`ifndef EPU_CONFIG_SVH
`define EPU_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame limits, in macroblocks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define EPU_MAX_MB_W      64
`define EPU_MAX_MB_H      64
`define EPU_MB_SIZE       16
`define EPU_WORDS_PER_MB  64    // Four pixels per 32-bit word.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define EPU_PIXEL_W       8
`define EPU_COORD_W       6
`define EPU_DIM_W         12
`define EPU_SAD_W         16    // 255 * 256 still fits.

`endif

// ==== hw/epu_pkg.sv ====
`include "epu_config.svh"

package epu_pkg;

    localparam int MB_SIZE = `EPU_MB_SIZE;

    typedef logic [`EPU_PIXEL_W-1:0] pixel_t;
    typedef logic [`EPU_COORD_W-1:0] mb_coord_t;
    typedef logic [`EPU_DIM_W-1:0]   frame_dim_t;
    typedef logic [`EPU_SAD_W-1:0]   sad_t;

    // Indexed as [row][column].
    typedef pixel_t [MB_SIZE-1:0][MB_SIZE-1:0] mb_matrix_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_LOAD,
        FETCH_WAIT
    } fetch_state_t;

    typedef enum logic [1:0] {
        COST_IDLE,
        COST_SUM,
        COST_SAD,
        COST_DONE
    } cost_state_t;

endpackage

// ==== hw/mb_fetch_if.sv ====
`timescale 1ns/100ps

interface mb_fetch_if;

    logic                 valid;
    epu_pkg::mb_coord_t   mb_x;
    epu_pkg::mb_coord_t   mb_y;
    epu_pkg::mb_matrix_t  matrix;
    logic                 ready;    // Completes the transfer together with valid.

    modport fetch (
        output valid,
        output mb_x,
        output mb_y,
        output matrix,
        input  ready
    );

    modport cost (
        input  valid,
        input  mb_x,
        input  mb_y,
        input  matrix,
        output ready
    );

endinterface

// ==== hw/mb_fetch.sv ====
`timescale 1ns/100ps
`include "epu_config.svh"

module mb_fetch (
    input  logic                clk,
    input  logic                rst,
    input  logic                h264_reset_i,
    input  logic                h264_en_i,
    input  epu_pkg::frame_dim_t frame_width_i,
    input  epu_pkg::frame_dim_t frame_height_i,
    input  logic [31:0]         data_word_i,
    input  logic                data_valid_i,
    output logic                fetch_req_o,
    mb_fetch_if.fetch           mb_o
);

    localparam int CNT_W = $clog2(`EPU_WORDS_PER_MB);

    epu_pkg::fetch_state_t state_q;
    epu_pkg::fetch_state_t state_d;
    logic [CNT_W-1:0]      word_cnt_q;
    logic [3:0]            row;
    logic [3:0]            col;
    logic                  accept;
    logic                  last_word;
    logic                  transfer;
    logic                  valid_q;
    epu_pkg::mb_matrix_t   matrix_q;
    logic [7:0]            mb_cols;
    logic [7:0]            mb_rows;
    epu_pkg::mb_coord_t    last_col;
    epu_pkg::mb_coord_t    mb_x_q;
    epu_pkg::mb_coord_t    mb_y_q;
    logic                  frame_done_q;
    logic                  frame_end;

    assign fetch_req_o = h264_en_i && (state_q == epu_pkg::FETCH_LOAD);
    assign accept      = fetch_req_o && data_valid_i;
    assign last_word   = accept && (word_cnt_q == CNT_W'(`EPU_WORDS_PER_MB - 1));
    assign transfer    = valid_q && mb_o.ready;

    // Four words per macroblock row, byte 0 leftmost.
    assign row = word_cnt_q[CNT_W-1:2];
    assign col = {word_cnt_q[1:0], 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mb_cols = frame_width_i[11:4];
    assign mb_rows = (frame_height_i[11:4] > 8'(`EPU_MAX_MB_H)) ?
                     8'(`EPU_MAX_MB_H) : frame_height_i[11:4];

    always_comb begin
        if (mb_cols == 8'd0)
            last_col = '0;
        else if (mb_cols > 8'(`EPU_MAX_MB_W))
            last_col = 6'(`EPU_MAX_MB_W - 1);   // The width macro is only a ceiling.
        else
            last_col = 6'(mb_cols - 8'd1);
    end

    assign frame_end = frame_done_q || (mb_rows == 8'd0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_d = state_q;
        case (state_q)
            epu_pkg::FETCH_IDLE: if (h264_en_i && !frame_end) state_d = epu_pkg::FETCH_LOAD;
            epu_pkg::FETCH_LOAD: if (last_word) state_d = epu_pkg::FETCH_WAIT;
            epu_pkg::FETCH_WAIT: if (transfer) state_d = epu_pkg::FETCH_IDLE;
            default:             state_d = epu_pkg::FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            state_q    <= epu_pkg::FETCH_IDLE;
            word_cnt_q <= '0;
            valid_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept)
                word_cnt_q <= word_cnt_q + 1'b1;   // Wraps to zero after the last word.
            if (last_word)
                valid_q <= 1'b1;
            else if (transfer)
                valid_q <= 1'b0;
        end
    end

    // Raster walk. Coordinates move on once the cost block has taken the macroblock.
    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            mb_x_q       <= '0;
            mb_y_q       <= '0;
            frame_done_q <= 1'b0;
        end else if (transfer) begin
            if (mb_x_q >= last_col) begin
                mb_x_q <= '0;
                mb_y_q <= mb_y_q + 1'b1;
                if (({2'b00, mb_y_q} + 8'd1) == mb_rows)
                    frame_done_q <= 1'b1;
            end else begin
                mb_x_q <= mb_x_q + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (accept) begin
            matrix_q[row][col]        <= data_word_i[7:0];
            matrix_q[row][col + 4'd1] <= data_word_i[15:8];
            matrix_q[row][col + 4'd2] <= data_word_i[23:16];
            matrix_q[row][col + 4'd3] <= data_word_i[31:24];
        end
    end

    assign mb_o.valid  = valid_q;
    assign mb_o.mb_x   = mb_x_q;
    assign mb_o.mb_y   = mb_y_q;
    assign mb_o.matrix = matrix_q;

endmodule

// ==== hw/mb_dc_cost.sv ====
`timescale 1ns/100ps

module mb_dc_cost (
    input  logic               clk,
    input  logic               rst,
    input  logic               h264_reset_i,
    mb_fetch_if.cost           mb_i,
    output logic               mb_done_o,
    output epu_pkg::mb_coord_t mb_x_o,
    output epu_pkg::mb_coord_t mb_y_o,
    output epu_pkg::pixel_t    mb_dc_o,
    output epu_pkg::sad_t      mb_sad_o
);

    epu_pkg::cost_state_t state_q;
    epu_pkg::cost_state_t state_d;
    logic [3:0]           row_q;
    logic                 last_row;
    logic [15:0]          sum_q;
    logic [15:0]          sum_round;
    epu_pkg::pixel_t      dc;
    epu_pkg::sad_t        sad_q;
    logic [11:0]          row_sum;      // 16 * 255 at most.
    logic [11:0]          row_sad;

    assign last_row = (row_q == 4'd15);

    // Rounded mean of 256 pixels. Stable for the whole SAD pass.
    assign sum_round = sum_q + 16'd128;
    assign dc        = sum_round[15:8];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One matrix row per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin : row_math
        epu_pkg::pixel_t pix;
        row_sum = '0;
        row_sad = '0;
        for (int c = 0; c < epu_pkg::MB_SIZE; c++) begin
            pix     = mb_i.matrix[row_q][c];
            row_sum = row_sum + 12'(pix);
            row_sad = row_sad + 12'((pix > dc) ? (pix - dc) : (dc - pix));
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            epu_pkg::COST_IDLE: if (mb_i.valid) state_d = epu_pkg::COST_SUM;
            epu_pkg::COST_SUM:  if (last_row) state_d = epu_pkg::COST_SAD;
            epu_pkg::COST_SAD:  if (last_row) state_d = epu_pkg::COST_DONE;
            default:            state_d = epu_pkg::COST_IDLE;   // Done lasts one cycle.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            state_q <= epu_pkg::COST_IDLE;
            row_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == epu_pkg::COST_SUM || state_q == epu_pkg::COST_SAD)
                row_q <= row_q + 4'd1;                  // Wraps between the two passes.
            else
                row_q <= '0;
        end
    end

    // Accumulators start clean when a new macroblock is seen.
    always_ff @(posedge clk) begin
        if (state_q == epu_pkg::COST_IDLE) begin
            sum_q <= '0;
            sad_q <= '0;
        end else if (state_q == epu_pkg::COST_SUM) begin
            sum_q <= sum_q + 16'(row_sum);
        end else if (state_q == epu_pkg::COST_SAD) begin
            sad_q <= sad_q + 16'(row_sad);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst || h264_reset_i) begin
            mb_x_o <= '0;
            mb_y_o <= '0;
        end else if (state_q == epu_pkg::COST_SAD && last_row) begin
            mb_x_o <= mb_i.mb_x;
            mb_y_o <= mb_i.mb_y;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == epu_pkg::COST_SAD && last_row) begin
            mb_dc_o  <= dc;
            mb_sad_o <= sad_q + 16'(row_sad);  // Includes the last row.
        end
    end

    assign mb_done_o  = (state_q == epu_pkg::COST_DONE);
    assign mb_i.ready = (state_q == epu_pkg::COST_DONE);   // Releases fetch from wait.

endmodule

// ==== hw/epu_top.sv ====
`timescale 1ns/100ps

module epu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                h264_reset_i,
    input  logic                h264_en_i,
    input  epu_pkg::frame_dim_t frame_width_i,
    input  epu_pkg::frame_dim_t frame_height_i,
    input  logic [31:0]         data_word_i,
    input  logic                data_valid_i,
    output logic                fetch_req_o,
    output logic                mb_done_o,
    output epu_pkg::mb_coord_t  mb_x_o,
    output epu_pkg::mb_coord_t  mb_y_o,
    output epu_pkg::pixel_t     mb_dc_o,
    output epu_pkg::sad_t       mb_sad_o
);

    mb_fetch_if mb_bus ();

    mb_fetch u_fetch (
        .clk            (clk),
        .rst            (rst),
        .h264_reset_i   (h264_reset_i),
        .h264_en_i      (h264_en_i),
        .frame_width_i  (frame_width_i),
        .frame_height_i (frame_height_i),
        .data_word_i    (data_word_i),
        .data_valid_i   (data_valid_i),
        .fetch_req_o    (fetch_req_o),
        .mb_o           (mb_bus.fetch)
    );

    mb_dc_cost u_cost (
        .clk          (clk),
        .rst          (rst),
        .h264_reset_i (h264_reset_i),
        .mb_i         (mb_bus.cost),
        .mb_done_o    (mb_done_o),
        .mb_x_o       (mb_x_o),
        .mb_y_o       (mb_y_o),
        .mb_dc_o      (mb_dc_o),
        .mb_sad_o     (mb_sad_o)
    );

endmodule

// ==== verification/epu_assertions.sv ====
`timescale 1ns/100ps

module epu_assertions (
    input logic                clk,
    input logic                rst,
    input logic                soft_rst_i,
    input logic                data_valid_i,
    input logic                fetch_req_i,
    input logic                valid_i,
    input logic                ready_i,
    input epu_pkg::mb_coord_t  mb_x_i,
    input epu_pkg::mb_coord_t  mb_y_i,
    input epu_pkg::mb_matrix_t matrix_i,
    input logic                done_i
);

    int fail_count = 0;

    // Words are only offered while the fetch block asks for them.
    data_in_request: assert property (@(posedge clk) disable iff (rst)
        data_valid_i |-> fetch_req_i)
        else begin
            fail_count++;
            $error("data strobe without a fetch request");
        end

    // The macroblock and its coordinates hold still until the cost block takes them.
    valid_until_transfer: assert property (@(posedge clk) disable iff (rst || soft_rst_i)
        (valid_i && !ready_i) |=> (valid_i && $stable(mb_x_i) && $stable(mb_y_i)
                                   && $stable(matrix_i)))
        else begin
            fail_count++;
            $error("macroblock changed or valid dropped before the transfer");
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        done_i |-> (valid_i && ready_i) ##1 !done_i)
        else begin
            fail_count++;
            $error("result strobe outside a transfer or longer than one cycle");
        end

    no_request_in_wait: assert property (@(posedge clk) disable iff (rst)
        (valid_i && !ready_i) |-> !fetch_req_i)
        else begin
            fail_count++;
            $error("fetch request while waiting for the cost block");
        end

endmodule

bind mb_fetch epu_assertions fetch_props (
    .clk          (clk),
    .rst          (rst),
    .soft_rst_i   (h264_reset_i),
    .data_valid_i (data_valid_i),
    .fetch_req_i  (fetch_req_o),
    .valid_i      (valid_q),
    .ready_i      (transfer),
    .mb_x_i       (mb_x_q),
    .mb_y_i       (mb_y_q),
    .matrix_i     (matrix_q),
    .done_i       (1'b0)
);

bind mb_dc_cost epu_assertions cost_props (
    .clk          (clk),
    .rst          (rst),
    .soft_rst_i   (h264_reset_i),
    .data_valid_i (1'b0),
    .fetch_req_i  (1'b0),
    .valid_i      (mb_i.valid),
    .ready_i      (mb_i.ready),
    .mb_x_i       (mb_i.mb_x),
    .mb_y_i       (mb_i.mb_y),
    .matrix_i     (mb_i.matrix),
    .done_i       (mb_done_o)
);

// ==== verification/epu_tb.sv ====
`timescale 1ns/100ps
`include "epu_config.svh"

module epu_tb;

    localparam int NUM_MB      = 15;
    localparam int WORD_CYCLES = 4;    // Worst case per word at the highest gap rate.
    localparam int CYCLE_LIMIT = NUM_MB * (`EPU_WORDS_PER_MB * WORD_CYCLES + 40) + 1500;
    localparam int PIX_PER_MB  = `EPU_MB_SIZE * `EPU_MB_SIZE;

    logic                clk;
    logic                rst;
    logic                h264_reset_i;
    logic                h264_en_i;
    epu_pkg::frame_dim_t frame_width_i;
    epu_pkg::frame_dim_t frame_height_i;
    logic [31:0]         data_word_i;
    logic                data_valid_i;
    logic                fetch_req_o;
    logic                mb_done_o;
    epu_pkg::mb_coord_t  mb_x_o;
    epu_pkg::mb_coord_t  mb_y_o;
    epu_pkg::pixel_t     mb_dc_o;
    epu_pkg::sad_t       mb_sad_o;

    logic [31:0]         lcg_state = 32'd33789;
    epu_pkg::pixel_t     pix_sent [PIX_PER_MB];   // Pixels of the macroblock being sent.
    epu_pkg::mb_coord_t  exp_x_q [$];
    epu_pkg::mb_coord_t  exp_y_q [$];
    epu_pkg::pixel_t     exp_dc_q [$];
    epu_pkg::sad_t       exp_sad_q [$];
    int                  exp_col = 0;
    int                  exp_row = 0;
    int                  mb_per_row = 1;
    int                  err_count = 0;
    int                  test_err_start = 0;
    int                  results_seen = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;
    int                  cycles = 0;
    int                  asrt_fails = 0;

    epu_top epu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic compare_coords(input epu_pkg::mb_coord_t got_x, input epu_pkg::mb_coord_t got_y,
                                  input epu_pkg::mb_coord_t exp_x, input epu_pkg::mb_coord_t exp_y);
        if (got_x !== exp_x || got_y !== exp_y) begin
            $display("mismatch at %0t: coordinates (%0d,%0d), expected (%0d,%0d)",
                     $time, got_x, got_y, exp_x, exp_y);
            err_count++;
        end
    endtask

    task automatic compare_dc(input epu_pkg::pixel_t got, input epu_pkg::pixel_t expected);
        if (got !== expected) begin
            $display("mismatch at %0t: DC %0d, expected %0d", $time, got, expected);
            err_count++;
        end
    endtask

    task automatic compare_sad(input epu_pkg::sad_t got, input epu_pkg::sad_t expected);
        if (got !== expected) begin
            $display("mismatch at %0t: SAD %0d, expected %0d", $time, got, expected);
            err_count++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sends words until stop_at are accepted. A negative fill gives random pixels.
    task automatic feed_mb(input int gap_pct, input int fill, input int stop_at);
        int          n;
        logic [31:0] word;
        n = 0;
        while (n < stop_at) begin
            @(posedge clk);
            if (data_valid_i && fetch_req_o)
                n++;
            if (fetch_req_o && n < stop_at && ((lcg_next() >> 16) % 100) >= gap_pct) begin
                for (int k = 0; k < 4; k++) begin
                    word[8*k +: 8] = (fill < 0) ? epu_pkg::pixel_t'(lcg_next() >> 16)
                                                : epu_pkg::pixel_t'(fill);
                    pix_sent[4*n + k] = word[8*k +: 8];   // Byte 0 is the leftmost pixel.
                end
                data_word_i  <= word;
                data_valid_i <= 1'b1;
            end else begin
                data_valid_i <= 1'b0;
            end
        end
    endtask

    task automatic push_expected();
        int sum;
        int sad;
        int dc;
        sum = 0;
        sad = 0;
        foreach (pix_sent[i])
            sum += int'(pix_sent[i]);
        dc = (sum + 128) / 256;   // Rounded mean of 256 pixels.
        foreach (pix_sent[i])
            sad += (int'(pix_sent[i]) > dc) ? int'(pix_sent[i]) - dc : dc - int'(pix_sent[i]);
        exp_x_q.push_back(epu_pkg::mb_coord_t'(exp_col));
        exp_y_q.push_back(epu_pkg::mb_coord_t'(exp_row));
        exp_dc_q.push_back(epu_pkg::pixel_t'(dc));
        exp_sad_q.push_back(epu_pkg::sad_t'(sad));
        exp_col++;
        if (exp_col == mb_per_row) begin
            exp_col = 0;
            exp_row++;
        end
    endtask

    task automatic start_frame(input int width, input int height);
        @(posedge clk);
        frame_width_i  <= epu_pkg::frame_dim_t'(width);
        frame_height_i <= epu_pkg::frame_dim_t'(height);
        data_valid_i   <= 1'b0;
        h264_reset_i   <= 1'b1;
        @(posedge clk);
        h264_reset_i   <= 1'b0;
        mb_per_row = width / `EPU_MB_SIZE;
        exp_col    = 0;
        exp_row    = 0;
    endtask

    task automatic run_frame(input int width, input int height, input int gap_pct, input int fill);
        start_frame(width, height);
        repeat ((width / `EPU_MB_SIZE) * (height / `EPU_MB_SIZE)) begin
            feed_mb(gap_pct, fill, `EPU_WORDS_PER_MB);
            push_expected();
        end
    endtask

    task automatic wait_drained();
        while (exp_dc_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
    endtask

    task automatic begin_test();
        tests_run++;
        test_err_start = err_count;
        results_seen   = 0;
    endtask

    task automatic finish_test(input string name, input int n_results);
        wait_drained();
        if (results_seen != n_results) begin
            $display("error at %0t: %0d results seen instead of %0d", $time, results_seen, n_results);
            err_count++;
        end
        if (err_count != test_err_start)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (err_count == test_err_start) ? "ok" : "FAILED");
    endtask

    // Every result is checked against the oldest outstanding macroblock.
    always @(posedge clk) begin
        if (!rst && mb_done_o) begin
            results_seen++;
            if (exp_dc_q.size() == 0) begin
                $display("error at %0t: result with no macroblock outstanding", $time);
                err_count++;
            end else begin
                compare_coords(mb_x_o, mb_y_o, exp_x_q.pop_front(), exp_y_q.pop_front());
                compare_dc(mb_dc_o, exp_dc_q.pop_front());
                compare_sad(mb_sad_o, exp_sad_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst            = 1'b1;
        h264_reset_i   = 1'b0;
        h264_en_i      = 1'b0;
        frame_width_i  = 12'd64;
        frame_height_i = 12'd32;
        data_word_i    = '0;
        data_valid_i   = 1'b0;
        repeat (5) @(posedge clk);
        rst       <= 1'b0;
        h264_en_i <= 1'b1;

        begin_test();
        run_frame(64, 32, 0, -1);
        finish_test("continuous 64x32 frame in raster order", 8);

        begin_test();
        repeat (200) begin
            @(posedge clk);
            if (fetch_req_o) begin
                $display("error at %0t: fetch request raised after the last macroblock", $time);
                err_count++;
            end
        end
        finish_test("idle after the frame end", 0);

        begin_test();
        run_frame(48, 16, 40, -1);
        finish_test("random gaps in the word stream", 3);

        begin_test();
        start_frame(32, 16);
        feed_mb(0, -1, 20);   // Abandoned part way through the first macroblock.
        run_frame(32, 16, 20, -1);
        finish_test("soft reset during a load", 2);

        begin_test();
        run_frame(16, 16, 0, 0);
        wait_drained();
        run_frame(16, 16, 10, 255);
        finish_test("flat macroblocks at 0 and 255", 2);

        asrt_fails = epu_top_inst.u_fetch.fetch_props.fail_count
                   + epu_top_inst.u_cost.cost_props.fail_count;
        if (asrt_fails != 0) begin
            $display("error: %0d assertion failures during the run", asrt_fails);
            err_count += asrt_fails;
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/epu_pkg.sv
hw/mb_fetch_if.sv
hw/mb_fetch.sv
hw/mb_dc_cost.sv
hw/epu_top.sv
verification/epu_assertions.sv
verification/epu_tb.sv
